//--- verilog/playfield_defs.svh
// widths assume a 64K-word video RAM of 16-bit words; the pixel group size must stay a power of two
`ifndef PLAYFIELD_DEFS_SVH
`define PLAYFIELD_DEFS_SVH

// video RAM port
`define PF_ADDR_W       16      // word address, 64K words
`define PF_WORD_W       16      // data word

// pixel path
`define PF_COLOR_W      8       // colour index into the palette
`define PF_GROUP_PIX    8       // pixels built from one fetched group

// horizontal timing
`define PF_HRES_W       11      // h_count and window edge width
`define PF_FETCH_LEAD   16      // counts from left edge to first scanout cycle, covers a 6 cycle fetch

`endif

//--- verilog/playfield_pkg.sv
// shared playfield types; bpp code 3 has no name and is decoded as 8 bpp by the datapath
`include "playfield_defs.svh"

package playfield_pkg;

typedef enum logic [1:0] {
    BPP_1_ATTR = 2'd0,                          // 1 word per group, fg/bg nibbles in upper byte
    BPP_4      = 2'd1,                          // 2 words per group
    BPP_8      = 2'd2                           // 4 words per group
} bpp_e;

typedef enum logic [3:0] {
    FETCH_IDLE   = 4'h0,                        // waiting for line fetch
    FETCH_ADDR   = 4'h1,                        // first request of a group, stalls on full buffer
    FETCH_WAIT   = 4'h2,                        // memory latency slot
    FETCH_READ_0 = 4'h3,                        // capture word 0
    FETCH_READ_1 = 4'h4,                        // capture word 1
    FETCH_READ_2 = 4'h5,                        // capture word 2
    FETCH_READ_3 = 4'h6                         // capture word 3
} fetch_state_e;

typedef struct packed {
    logic                       blank;          // playfield off, border only
    bpp_e                       bpp;            // colour depth
    logic [`PF_COLOR_W-1:0]     colorbase;      // xor'd into every pixel
    logic [1:0]                 h_repeat;       // extra cycles per pixel
    logic [1:0]                 v_repeat;       // extra repeats per line
    logic [`PF_ADDR_W-1:0]      start_addr;     // first line of the frame
    logic [`PF_WORD_W-1:0]      line_len;       // words between line starts
} pf_cfg_t;

typedef struct packed {
    logic [`PF_HRES_W-1:0]      h_count;        // horizontal counter
    logic [`PF_HRES_W-1:0]      vid_left;       // left edge of visible area
    logic [`PF_HRES_W-1:0]      vid_right;      // right edge +1
    logic                       mem_fetch;      // fetch window
    logic                       mem_fetch_start;// strobe at start of line fetch
    logic                       end_of_line;    // strobe
    logic                       end_of_frame;   // strobe
} vid_timing_t;

typedef struct packed {
    logic                       sel;            // read strobe
    logic [`PF_ADDR_W-1:0]      addr;           // word address
} vram_rd_t;

typedef struct packed {
    logic [3:0]                 cap;            // one-hot word slot strobe
    logic [`PF_WORD_W-1:0]      data;           // word to store in that slot
    logic                       ready;          // all words of the group stored
} word_cap_t;

endpackage

//--- verilog/line_addr_gen.sv
// blank or end_of_frame wins over end_of_line; cfg changes take effect at the next reload only
`timescale 1ns/1ps
`include "playfield_defs.svh"

module line_addr_gen (
    input  logic                            clk,
    input  logic                            reset_i,
    input  playfield_pkg::pf_cfg_t          cfg_i,
    input  playfield_pkg::vid_timing_t      timing_i,
    output logic [`PF_ADDR_W-1:0]           line_start_o    // first word of current line
);

logic [`PF_ADDR_W-1:0]  line_start;
logic [1:0]             v_cnt;          // lines left before stepping

always_ff @(posedge clk) begin
    if (reset_i || cfg_i.blank || timing_i.end_of_frame) begin
        line_start <= cfg_i.start_addr;                 // top of frame
        v_cnt      <= cfg_i.v_repeat;
    end else if (timing_i.end_of_line) begin
        if (v_cnt != 2'd0) begin
            v_cnt      <= v_cnt - 1'b1;                 // show same data again
        end else begin
            v_cnt      <= cfg_i.v_repeat;
            line_start <= line_start + cfg_i.line_len;  // next display line
        end
    end
end

assign line_start_o = line_start;

endmodule

//--- verilog/playfield_fetch_ctrl.sv
// issues one vram read per cycle with fixed one-cycle latency; no wait states are supported
`timescale 1ns/1ps
`include "playfield_defs.svh"

module playfield_fetch_ctrl (
    input  logic                            clk,
    input  logic                            reset_i,
    input  playfield_pkg::pf_cfg_t          cfg_i,
    input  playfield_pkg::vid_timing_t      timing_i,
    input  logic [`PF_ADDR_W-1:0]           line_start_i,   // start of current display line
    input  logic                            buf_full_i,     // pixel buffer still holds a group
    input  logic [`PF_WORD_W-1:0]           vram_data_i,
    output playfield_pkg::vram_rd_t         vram_rd_o,
    output playfield_pkg::word_cap_t        word_cap_o
);

playfield_pkg::fetch_state_e    fetch_state, fetch_state_next;
logic [`PF_ADDR_W-1:0]          disp_addr, disp_addr_next;  // next display word to read
logic                           req_next;                   // issue a read this cycle
logic                           ready_q, ready_next;        // group complete
logic                           rd_sel;
logic [`PF_ADDR_W-1:0]          rd_addr;
logic                           wide;                       // 4 or 8 bpp, second word needed
logic                           deep;                       // 8 bpp, four words needed
logic [3:0]                     cap_slot;

always_comb begin
    wide             = (cfg_i.bpp != playfield_pkg::BPP_1_ATTR);
    deep             = wide && (cfg_i.bpp != playfield_pkg::BPP_4);    // code 3 acts as 8 bpp
    fetch_state_next = fetch_state;
    disp_addr_next   = disp_addr;
    req_next         = 1'b0;
    ready_next       = 1'b0;

    case (fetch_state)
        playfield_pkg::FETCH_IDLE: begin
            if (timing_i.mem_fetch) begin
                fetch_state_next = playfield_pkg::FETCH_ADDR;
            end
        end
        playfield_pkg::FETCH_ADDR: begin
            // a group still on its way into the buffer counts as full
            if (!buf_full_i && !ready_q) begin
                req_next         = 1'b1;                        // word 0
                fetch_state_next = playfield_pkg::FETCH_WAIT;
            end
        end
        playfield_pkg::FETCH_WAIT: begin
            req_next         = wide;                            // word 1
            fetch_state_next = playfield_pkg::FETCH_READ_0;
        end
        playfield_pkg::FETCH_READ_0: begin
            req_next         = deep;                            // word 2
            ready_next       = !wide;
            fetch_state_next = wide ? playfield_pkg::FETCH_READ_1 : playfield_pkg::FETCH_ADDR;
        end
        playfield_pkg::FETCH_READ_1: begin
            req_next         = deep;                            // word 3
            ready_next       = !deep;
            fetch_state_next = deep ? playfield_pkg::FETCH_READ_2 : playfield_pkg::FETCH_ADDR;
        end
        playfield_pkg::FETCH_READ_2: begin
            fetch_state_next = playfield_pkg::FETCH_READ_3;
        end
        playfield_pkg::FETCH_READ_3: begin
            ready_next       = 1'b1;
            fetch_state_next = playfield_pkg::FETCH_ADDR;
        end
        default: begin
            fetch_state_next = playfield_pkg::FETCH_IDLE;
        end
    endcase

    if (req_next) begin
        disp_addr_next = disp_addr + 1'b1;                      // one word per request
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        fetch_state <= playfield_pkg::FETCH_IDLE;
        disp_addr   <= '0;
        rd_sel      <= 1'b0;
        ready_q     <= 1'b0;
    end else if (timing_i.end_of_line) begin
        fetch_state <= playfield_pkg::FETCH_IDLE;               // abandon any partial group
        rd_sel      <= 1'b0;
        ready_q     <= 1'b0;
    end else if (timing_i.mem_fetch_start) begin
        fetch_state <= playfield_pkg::FETCH_ADDR;               // restart at the line start
        disp_addr   <= line_start_i;
        rd_sel      <= 1'b0;
        ready_q     <= 1'b0;
    end else begin
        fetch_state <= fetch_state_next;
        disp_addr   <= disp_addr_next;
        rd_sel      <= req_next;
        ready_q     <= ready_next;
    end
end

always_ff @(posedge clk) begin
    if (req_next) begin
        rd_addr <= disp_addr;                                   // held until the next request
    end
end

// each read state takes the word requested two states earlier
always_comb begin
    cap_slot[0] = (fetch_state == playfield_pkg::FETCH_READ_0);
    cap_slot[1] = (fetch_state == playfield_pkg::FETCH_READ_1);
    cap_slot[2] = (fetch_state == playfield_pkg::FETCH_READ_2);
    cap_slot[3] = (fetch_state == playfield_pkg::FETCH_READ_3);
end

assign vram_rd_o  = {rd_sel, rd_addr};
assign word_cap_o = {cap_slot, vram_data_i, ready_q};

endmodule

//--- verilog/pixel_expand.sv
// expansion follows cfg bpp at load time, so depth must not change while a group is in flight
`timescale 1ns/1ps
`include "playfield_defs.svh"

module pixel_expand (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  playfield_pkg::pf_cfg_t                      cfg_i,
    input  playfield_pkg::vid_timing_t                  timing_i,
    input  playfield_pkg::word_cap_t                    word_cap_i,
    input  logic                                        buf_take_i,     // scanout took the buffer
    output logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]   pix_buf_o,      // [7] is shown first
    output logic                                        buf_full_o
);

logic [3:0][`PF_WORD_W-1:0]                 words;      // captured words, slot 0 leftmost
logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]  group;      // expanded pixels
logic                                       buf_full;

always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
        if (word_cap_i.cap[i]) begin
            words[i] <= word_cap_i.data;
        end
    end
end

always_comb begin
    group = '0;
    case (cfg_i.bpp)
        playfield_pkg::BPP_1_ATTR: begin
            // bit set picks foreground nibble 15:12, clear picks background 11:8
            for (int i = 0; i < `PF_GROUP_PIX; i++) begin
                group[i] = {4'h0, words[0][i] ? words[0][15:12] : words[0][11:8]};
            end
        end
        playfield_pkg::BPP_4: begin
            for (int i = 0; i < 4; i++) begin
                group[7-i] = {4'h0, words[0][15-4*i -: 4]};     // msb nibble first
                group[3-i] = {4'h0, words[1][15-4*i -: 4]};
            end
        end
        default: begin
            // 8 bpp and the unnamed code 3
            for (int i = 0; i < 4; i++) begin
                group[7-2*i] = words[i][15:8];                  // high byte first
                group[6-2*i] = words[i][7:0];
            end
        end
    endcase
end

always_ff @(posedge clk) begin
    if (word_cap_i.ready) begin
        pix_buf_o <= group;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        buf_full <= 1'b0;
    end else if (timing_i.mem_fetch_start) begin
        buf_full <= 1'b0;               // drop leftovers of previous line
    end else if (word_cap_i.ready) begin
        buf_full <= 1'b1;
    end else if (buf_take_i) begin
        buf_full <= 1'b0;
    end
end

assign buf_full_o = buf_full;

endmodule

//--- verilog/pixel_scanout.sv
// window edges are offset by the fetch lead; an empty buffer at group end shows border pixels
`timescale 1ns/1ps
`include "playfield_defs.svh"

module pixel_scanout (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  playfield_pkg::pf_cfg_t                      cfg_i,
    input  playfield_pkg::vid_timing_t                  timing_i,
    input  logic [`PF_COLOR_W-1:0]                      border_color_i,
    input  logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]   pix_buf_i,
    input  logic                                        buf_full_i,
    output logic                                        buf_take_o,     // one cycle, buffer moved
    output logic [`PF_COLOR_W-1:0]                      pf_color_index_o
);

localparam int                      pix_x_w    = $clog2(`PF_GROUP_PIX);
localparam logic [`PF_HRES_W-1:0]   fetch_lead = `PF_FETCH_LEAD;

logic                                       scanout;        // pixels being shown
logic [1:0]                                 h_cnt;          // repeat countdown of head pixel
logic [pix_x_w-1:0]                         pix_x;          // head position in group
logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]  shifter;        // [7] is on screen
logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]  next_group;
logic                                       scan_start;
logic                                       scan_end;
logic                                       group_end;      // last cycle of eighth pixel

always_comb begin
    scan_start = timing_i.mem_fetch && !cfg_i.blank &&
                 (timing_i.h_count == timing_i.vid_left + fetch_lead);
    scan_end   = (timing_i.h_count >= timing_i.vid_right + fetch_lead);
    group_end  = scanout && (h_cnt == 2'd0) && (&pix_x);
    next_group = buf_full_i ? pix_buf_i : {`PF_GROUP_PIX{border_color_i}};
    buf_take_o = buf_full_i && (scan_start || group_end);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        scanout <= 1'b0;
        h_cnt   <= '0;
        pix_x   <= '0;
    end else begin
        if (scan_start) begin
            scanout <= 1'b1;
            h_cnt   <= cfg_i.h_repeat;
            pix_x   <= '0;
        end else if (scanout) begin
            if (h_cnt != 2'd0) begin
                h_cnt <= h_cnt - 1'b1;              // hold pixel
            end else begin
                h_cnt <= cfg_i.h_repeat;
                pix_x <= pix_x + 1'b1;              // wraps at group end
            end
        end
        if (scan_end || timing_i.end_of_line || cfg_i.blank) begin
            scanout <= 1'b0;                        // right edge, border from here on
        end
    end
end

always_ff @(posedge clk) begin
    if (scan_start || group_end) begin
        shifter <= next_group;
    end else if (scanout && h_cnt == 2'd0) begin
        shifter <= {shifter[`PF_GROUP_PIX-2:0], border_color_i};   // next pixel to head
    end
end

assign pf_color_index_o = (scanout ? shifter[`PF_GROUP_PIX-1] : border_color_i) ^ cfg_i.colorbase;

endmodule

//--- verilog/video_playfield.sv
// expects mem_fetch_start at least 8 counts before vid_left + lead, and cfg held stable per frame
`timescale 1ns/1ps
`include "playfield_defs.svh"

module video_playfield (
    input  logic                            clk,
    input  logic                            reset_i,
    input  playfield_pkg::vid_timing_t      timing_i,       // from video timing generator
    input  playfield_pkg::pf_cfg_t          cfg_i,
    input  logic [`PF_COLOR_W-1:0]          border_color_i,
    output playfield_pkg::vram_rd_t         vram_rd_o,
    input  logic [`PF_WORD_W-1:0]           vram_data_i,
    output logic [`PF_COLOR_W-1:0]          pf_color_index_o
);

logic [`PF_ADDR_W-1:0]                      line_start;     // line_addr_gen to fetch
playfield_pkg::word_cap_t                   word_cap;       // fetch to expander
logic [`PF_GROUP_PIX-1:0][`PF_COLOR_W-1:0]  pix_buf;        // expander to scanout
logic                                       buf_full;
logic                                       buf_take;       // scanout back to expander

line_addr_gen u_line_addr (
    .clk            (clk),
    .reset_i        (reset_i),
    .cfg_i          (cfg_i),
    .timing_i       (timing_i),
    .line_start_o   (line_start)
);

playfield_fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .reset_i        (reset_i),
    .cfg_i          (cfg_i),
    .timing_i       (timing_i),
    .line_start_i   (line_start),
    .buf_full_i     (buf_full),
    .vram_data_i    (vram_data_i),
    .vram_rd_o      (vram_rd_o),
    .word_cap_o     (word_cap)
);

pixel_expand u_expand (
    .clk            (clk),
    .reset_i        (reset_i),
    .cfg_i          (cfg_i),
    .timing_i       (timing_i),
    .word_cap_i     (word_cap),
    .buf_take_i     (buf_take),
    .pix_buf_o      (pix_buf),
    .buf_full_o     (buf_full)
);

pixel_scanout u_scanout (
    .clk                (clk),
    .reset_i            (reset_i),
    .cfg_i              (cfg_i),
    .timing_i           (timing_i),
    .border_color_i     (border_color_i),
    .pix_buf_i          (pix_buf),
    .buf_full_i         (buf_full),
    .buf_take_o         (buf_take),
    .pf_color_index_o   (pf_color_index_o)
);

endmodule

//--- dv/tb_clock_gen.sv
// free-running clock that starts low, so the first rising edge comes half a period after time zero
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns = 40.0                 // 25 MHz pixel clock
) (
    output logic clk_o
);

initial begin
    clk_o = 1'b0;
    forever begin
        #(period_ns / 2.0) clk_o = ~clk_o;
    end
end

endmodule

//--- dv/playfield_assertions.sv
// bound into video_playfield and reaches the fetch FSM state through its instance name there
`timescale 1ns/1ps
`include "playfield_defs.svh"

module playfield_assertions (
    input  logic                            clk,
    input  logic                            reset_i,
    input  playfield_pkg::pf_cfg_t          cfg_i,
    input  playfield_pkg::vid_timing_t      timing_i,
    input  logic [`PF_COLOR_W-1:0]          border_color_i,
    input  logic [`PF_COLOR_W-1:0]          pf_color_index_i,
    input  logic                            rd_sel_i,       // video RAM read strobe
    input  playfield_pkg::fetch_state_e     fetch_state_i,
    input  logic                            buf_full_i
);

// reset clears the read strobe on the edge it is seen
a_no_read_in_reset: assert property (@(posedge clk) $past(reset_i) |-> !rd_sel_i)
    else $error("video RAM read strobe high during reset");

// end of line or blank stops scanout on the following edge
a_border_outside: assert property (@(posedge clk) disable iff (reset_i)
    $past(timing_i.end_of_line || cfg_i.blank) |->
    (pf_color_index_i == (border_color_i ^ cfg_i.colorbase)))
    else $error("output differs from border colour outside scanout");

a_legal_state: assert property (@(posedge clk) disable iff (reset_i)
    fetch_state_i inside {playfield_pkg::FETCH_IDLE, playfield_pkg::FETCH_ADDR,
                          playfield_pkg::FETCH_WAIT, playfield_pkg::FETCH_READ_0,
                          playfield_pkg::FETCH_READ_1, playfield_pkg::FETCH_READ_2,
                          playfield_pkg::FETCH_READ_3})
    else $error("fetch FSM in an undefined state");

// full buffer is the only stall point of the fetch FSM
a_stall_on_full: assert property (@(posedge clk) disable iff (reset_i)
    (fetch_state_i == playfield_pkg::FETCH_ADDR && buf_full_i) |=> !rd_sel_i)
    else $error("read issued while pixel buffer full");

endmodule

bind video_playfield playfield_assertions u_assertions (
    .clk                (clk),
    .reset_i            (reset_i),
    .cfg_i              (cfg_i),
    .timing_i           (timing_i),
    .border_color_i     (border_color_i),
    .pf_color_index_i   (pf_color_index_o),
    .rd_sel_i           (vram_rd_o.sel),
    .fetch_state_i      (u_fetch_ctrl.fetch_state),
    .buf_full_i         (buf_full)
);

//--- dv/tb_video_playfield.sv
// 64-word video RAM model wraps every address modulo 64; window end must stay below 2047
`timescale 1ns/1ps
`include "playfield_defs.svh"

module tb_video_playfield;

localparam int h_total   = 160;                     // counts per line
localparam int ram_words = 64;

logic                           clk;
logic                           reset;
playfield_pkg::vid_timing_t     timing;
playfield_pkg::pf_cfg_t         cfg;
logic [`PF_COLOR_W-1:0]         border_color;
playfield_pkg::vram_rd_t        vram_rd;
logic [`PF_WORD_W-1:0]          vram_data;
logic [`PF_COLOR_W-1:0]         pf_color_index;

logic [`PF_WORD_W-1:0]          vram [ram_words];
logic [31:0]                    lfsr;
playfield_pkg::pf_cfg_t         next_cfg;           // takes effect at the next line start
logic [`PF_COLOR_W-1:0]         next_border;
int                             next_left;
int                             next_right;
int                             tests, checks, errors, test_checks, test_errors;

tb_clock_gen u_clk (.clk_o(clk));

video_playfield uut (
    .clk                (clk),
    .reset_i            (reset),
    .timing_i           (timing),
    .cfg_i              (cfg),
    .border_color_i     (border_color),
    .vram_rd_o          (vram_rd),
    .vram_data_i        (vram_data),
    .pf_color_index_o   (pf_color_index)
);

// word follows 1 ns after the sampling edge and stays until the next request
always @(posedge clk) begin : vram_model
    playfield_pkg::vram_rd_t req;
    req = vram_rd;
    #1;
    if (req.sel) begin
        vram_data = vram[req.addr[5:0]];
    end
end

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v    = {v[30:0], lfsr[0]};                  // one step per bit taken
    end
endtask

task automatic fill_vram();
    logic [31:0] v;
    for (int a = 0; a < ram_words; a++) begin
        rand_bits(`PF_WORD_W, v);
        vram[a] = v[`PF_WORD_W-1:0];
    end
endtask

// pixel p counted from the left of a line that starts at word base
function automatic logic [7:0] model_pixel(input playfield_pkg::pf_cfg_t c,
                                           input logic [15:0] base, input int p);
    int          g;
    int          q;
    logic [15:0] w;
    g = p / 8;                                      // group
    q = p % 8;                                      // position in group
    if (c.bpp == playfield_pkg::BPP_1_ATTR) begin
        w = vram[(int'(base) + g) % ram_words];
        return w[7 - q] ? {4'h0, w[15:12]} : {4'h0, w[11:8]};  // fg or bg nibble
    end else if (c.bpp == playfield_pkg::BPP_4) begin
        w = vram[(int'(base) + 2 * g + q / 4) % ram_words];
        return 8'((w >> (12 - 4 * (q % 4))) & 16'h000f);
    end
    w = vram[(int'(base) + 4 * g + q / 2) % ram_words];       // 8 bpp and code 3
    return (q % 2 == 0) ? w[15:8] : w[7:0];
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("ERROR %s: expected %0h actual %0h", name, expected, actual);
    end
endtask

// one full line with inputs driven 1 ns after the rising edge and output sampled at the falling edge
task automatic run_line(input string name, input logic [15:0] base, input logic last);
    logic [7:0] expected;
    logic       got_req;
    int         s;
    int         e;
    got_req = 1'b0;
    s       = next_left + `PF_FETCH_LEAD;           // scan start count
    e       = next_right + `PF_FETCH_LEAD;          // last count showing a pixel
    for (int k = 0; k < h_total; k++) begin
        @(posedge clk);
        #1;
        if (k == 0) begin
            cfg              = next_cfg;
            border_color     = next_border;
            timing.vid_left  = 11'(next_left);
            timing.vid_right = 11'(next_right);
        end
        timing.h_count         = 11'(k);
        timing.mem_fetch       = 1'b1;
        timing.mem_fetch_start = (k == 0);
        timing.end_of_line     = (k == h_total - 1);
        timing.end_of_frame    = last && (k == h_total - 1);
        @(negedge clk);
        got_req = got_req || vram_rd.sel;
        if (k == 8 && !got_req) begin               // fetch start timeout
            errors++;
            $display("%s: no video RAM read within 8 cycles of fetch start", name);
        end
        if (!cfg.blank && k > s && k <= e) begin
            expected = model_pixel(cfg, base, (k - s - 1) / (int'(cfg.h_repeat) + 1));
            expected = expected ^ cfg.colorbase;
        end else begin
            expected = border_color ^ cfg.colorbase;
        end
        check_value(name, expected, pf_color_index);
    end
endtask

task automatic run_frame(input string name, input int lines);
    logic [15:0] base;
    for (int j = 0; j < lines; j++) begin
        base = next_cfg.start_addr +
               16'((j / (int'(next_cfg.v_repeat) + 1)) * int'(next_cfg.line_len));
        run_line(name, base, j == lines - 1);
    end
endtask

// new RAM contents and colours followed by one blank line that reloads the line address
task automatic start_test(input string name, input logic [1:0] bpp, input logic [1:0] h_rep,
                          input logic [1:0] v_rep, input int left, input int right);
    logic [31:0] v;
    fill_vram();
    next_cfg.bpp      = playfield_pkg::bpp_e'(bpp);
    next_cfg.h_repeat = h_rep;
    next_cfg.v_repeat = v_rep;
    rand_bits(8, v);
    next_cfg.colorbase = v[7:0];
    rand_bits(8, v);
    next_border = v[7:0];
    rand_bits(6, v);
    next_cfg.start_addr = 16'(v[5:0]);
    rand_bits(6, v);
    next_cfg.line_len = 16'(v[5:0]);
    next_left      = left;
    next_right     = right;
    next_cfg.blank = 1'b1;
    run_line(name, 16'h0, 1'b0);
    next_cfg.blank = 1'b0;
endtask

task automatic end_test(input string name);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
endtask

initial begin
    logic [31:0] v;
    string       name;
    lfsr         = 32'h4b68e6f9;
    reset        = 1'b1;
    timing       = '0;
    cfg          = '0;
    vram_data    = '0;
    next_cfg     = '0;
    next_border  = '0;
    next_left    = 0;
    next_right   = 0;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    test_checks  = 0;
    test_errors  = 0;
    rand_bits(8, v);
    cfg.colorbase = v[7:0];                         // reset output shows the xor of random colours
    rand_bits(8, v);
    border_color = v[7:0];
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value("reset_blank", border_color ^ cfg.colorbase, pf_color_index);
    start_test("reset_blank", 2'd0, 2'd0, 2'd0, 8, 72);
    end_test("reset_blank");
    for (int d = 0; d < 3; d++) begin               // 1 bpp attr, 4 bpp, 8 bpp
        name = $sformatf("depth_%0d", d);
        start_test(name, 2'(d), 2'd0, 2'd0, 8, 72);
        run_frame(name, 2);
        end_test(name);
    end
    for (int r = 0; r < 4; r++) begin
        rand_bits(2, v);
        name = $sformatf("hrepeat_%0d", r);
        start_test(name, v[1:0], 2'(r), 2'd0, 4, 104);
        run_frame(name, 2);
        end_test(name);
    end
    rand_bits(4, v);
    start_test("vstep", v[1:0], 2'd0, v[3:2], 8, 40);
    run_frame("vstep", 5);
    run_frame("vstep", 5);                          // back to start_addr after end_of_frame
    end_test("vstep");
    for (int w = 0; w < 4; w++) begin
        rand_bits(16, v);
        name = $sformatf("window_%0d", w);
        start_test(name, v[1:0], v[3:2], 2'd0, int'(v[8:4]), int'(v[8:4]) + int'(v[15:9]));
        run_frame(name, 1);
        end_test(name);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

//--- video_playfield.f
+incdir+verilog
verilog/playfield_pkg.sv
verilog/line_addr_gen.sv
verilog/playfield_fetch_ctrl.sv
verilog/pixel_expand.sv
verilog/pixel_scanout.sv
verilog/video_playfield.sv
dv/tb_clock_gen.sv
dv/playfield_assertions.sv
dv/tb_video_playfield.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_playfield
FILELIST  ?= video_playfield.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
